//--- design/i2cMonPkg.sv
package i2cMonPkg;

	// ********************
	// frame geometry
	// ********************

	localparam int BitsPerByte = 9; // eight data bits and the acknowledge
	localparam int MaxFrameBytes = 8;
	localparam int AckSlot = BitsPerByte - 1; // slot of the acknowledge within a byte
	localparam int ByteIdxWidth = $clog2(MaxFrameBytes);
	localparam int SlotIdxWidth = $clog2(BitsPerByte);

	// room for a complete frame of the largest size
	localparam int BitCountWidth = $clog2(MaxFrameBytes * BitsPerByte + 1);

	typedef logic [BitCountWidth-1:0] bitCountT;

	// ********************
	// results
	// ********************

	localparam int FrameCountWidth = 16;

	typedef logic [FrameCountWidth-1:0] frameCountT;

	typedef enum logic [1:0] {
		statusIdle,
		statusActive,
		statusMatched,
		statusFailed
	} frameStatusE;

endpackage

//--- design/i2cLineSync.sv
`timescale 1ns/1ps

module i2cLineSync #(
	parameter int SyncStages = 2
) (
	input logic clk,
	input logic reset,
	input logic scl,
	input logic sda,
	output logic sclRise,
	output logic sdaBit,
	output logic startSeen,
	output logic stopSeen
);

	logic [SyncStages-1:0] sclChain;
	logic [SyncStages-1:0] sdaChain;
	logic sclNow;
	logic sdaNow;
	logic sclPrev;
	logic sdaPrev;

	assign sclNow = sclChain[SyncStages-1];
	assign sdaNow = sdaChain[SyncStages-1];

	// ********************
	// synchronizers
	// ********************

	always_ff @(posedge clk) begin
		if (reset) begin
			sclChain <= '1; // idle bus has both lines high
			sdaChain <= '1;
			sclPrev <= 1'b1;
			sdaPrev <= 1'b1;
		end else begin
			sclChain <= {sclChain[SyncStages-2:0], scl};
			sdaChain <= {sdaChain[SyncStages-2:0], sda};
			sclPrev <= sclNow;
			sdaPrev <= sdaNow;
		end
	end

	// ********************
	// edge and condition pulses
	// ********************

	always_ff @(posedge clk) begin
		if (reset) begin
			sclRise <= 1'b0;
			startSeen <= 1'b0;
			stopSeen <= 1'b0;
		end else begin
			sclRise <= sclNow & ~sclPrev;
			startSeen <= sclNow & sclPrev & sdaPrev & ~sdaNow; // scl must already be high
			stopSeen <= sclNow & sclPrev & ~sdaPrev & sdaNow;
		end
	end

	always_ff @(posedge clk) begin
		sdaBit <= sdaNow; // lines up with sclRise
	end

endmodule

//--- design/i2cFrameMatcher.sv
`timescale 1ns/1ps

module i2cFrameMatcher import i2cMonPkg::*; #(
	parameter int NumBytes = 3,
	parameter logic [NumBytes*8-1:0] ExpectedFrame = 24'hA0_5C_3E
) (
	input logic clk,
	input logic reset,
	input logic sclRise,
	input logic sdaBit,
	input logic startSeen,
	input logic stopSeen,
	output frameStatusE frameStatus,
	output bitCountT bitsMatched,
	output logic frameDone
);

	localparam logic [ByteIdxWidth-1:0] LastByte = ByteIdxWidth'(NumBytes - 1);
	localparam logic [SlotIdxWidth-1:0] AckIdx = SlotIdxWidth'(AckSlot);

	logic [ByteIdxWidth-1:0] byteIdx;
	logic [SlotIdxWidth-1:0] slotIdx;
	logic isAck;
	logic lastBit;
	logic expBit;
	int dataIdx;

	// ********************
	// expected bit select
	// ********************

	always_comb begin
		isAck = (slotIdx == AckIdx);
		lastBit = isAck && (byteIdx == LastByte);
		// first byte on the bus sits in the top byte, msb first
		dataIdx = (NumBytes - 1 - int'(byteIdx)) * 8 + 7 - int'(slotIdx[2:0]);
		if (isAck) begin
			expBit = 1'b0; // acknowledge must be driven low
		end else begin
			expBit = ExpectedFrame[dataIdx];
		end
	end

	// ********************
	// frame state
	// ********************

	always_ff @(posedge clk) begin
		if (reset) begin
			frameStatus <= statusIdle;
			bitsMatched <= '0;
			byteIdx <= '0;
			slotIdx <= '0;
			frameDone <= 1'b0;
		end else begin
			frameDone <= 1'b0;
			if (startSeen) begin
				frameStatus <= statusActive; // a repeated start also lands here
				bitsMatched <= '0;
				byteIdx <= '0;
				slotIdx <= '0;
			end else if (frameStatus == statusActive) begin
				if (stopSeen) begin
					frameStatus <= statusFailed; // frame cut short
					frameDone <= 1'b1;
				end else if (sclRise) begin
					if (sdaBit != expBit) begin
						frameStatus <= statusFailed;
						frameDone <= 1'b1;
					end else begin
						bitsMatched <= bitsMatched + 1'b1;
						if (lastBit) begin
							frameStatus <= statusMatched;
							frameDone <= 1'b1;
						end else if (isAck) begin
							slotIdx <= '0;
							byteIdx <= byteIdx + 1'b1;
						end else begin
							slotIdx <= slotIdx + 1'b1;
						end
					end
				end
			end
		end
	end

endmodule

//--- design/i2cStatusReport.sv
`timescale 1ns/1ps

module i2cStatusReport import i2cMonPkg::*; (
	input logic clk,
	input logic reset,
	input frameStatusE frameStatus,
	input logic frameDone,
	output frameStatusE lastResult,
	output frameCountT matchCount,
	output frameCountT failCount
);

	localparam frameCountT CountMax = '1;

	logic isMatch;
	logic isFail;

	assign isMatch = (frameStatus == statusMatched);
	assign isFail = (frameStatus == statusFailed);

	// ********************
	// last result
	// ********************

	always_ff @(posedge clk) begin
		if (reset) begin
			lastResult <= statusIdle;
		end else if (frameDone) begin
			lastResult <= frameStatus; // held until the next frame ends
		end
	end

	// ********************
	// frame counters
	// ********************

	always_ff @(posedge clk) begin
		if (reset) begin
			matchCount <= '0;
			failCount <= '0;
		end else if (frameDone) begin
			if (isMatch && matchCount != CountMax) begin
				matchCount <= matchCount + 1'b1; // saturates at all ones
			end
			if (isFail && failCount != CountMax) begin
				failCount <= failCount + 1'b1;
			end
		end
	end

endmodule

//--- design/i2cFrameMonitor.sv
`timescale 1ns/1ps

module i2cFrameMonitor import i2cMonPkg::*; #(
	parameter int NumBytes = 3,
	parameter logic [NumBytes*8-1:0] ExpectedFrame = 24'hA0_5C_3E,
	parameter int SyncStages = 2
) (
	input logic clk,
	input logic reset,
	input logic scl,
	input logic sda,
	output frameStatusE frameStatus,
	output bitCountT bitsMatched,
	output logic frameDone,
	output frameStatusE lastResult,
	output frameCountT matchCount,
	output frameCountT failCount
);

	logic sclRise;
	logic sdaBit;
	logic startSeen;
	logic stopSeen;

	i2cLineSync #(
		.SyncStages(SyncStages)
	) lineSync (
		.clk(clk),
		.reset(reset),
		.scl(scl),
		.sda(sda),
		.sclRise(sclRise),
		.sdaBit(sdaBit),
		.startSeen(startSeen),
		.stopSeen(stopSeen)
	);

	i2cFrameMatcher #(
		.NumBytes(NumBytes),
		.ExpectedFrame(ExpectedFrame)
	) frameMatcher (
		.clk(clk),
		.reset(reset),
		.sclRise(sclRise),
		.sdaBit(sdaBit),
		.startSeen(startSeen),
		.stopSeen(stopSeen),
		.frameStatus(frameStatus),
		.bitsMatched(bitsMatched),
		.frameDone(frameDone)
	);

	i2cStatusReport statusReport (
		.clk(clk),
		.reset(reset),
		.frameStatus(frameStatus),
		.frameDone(frameDone),
		.lastResult(lastResult),
		.matchCount(matchCount),
		.failCount(failCount)
	);

endmodule

//--- include/i2cTbTasks.svh
`ifndef I2C_TB_TASKS_SVH
`define I2C_TB_TASKS_SVH

// ********************
// bus drivers
// ********************

localparam int SclHalf = 8; // clk cycles per scl half-period

// drives land 2 ns after the rising clock edge
task automatic waitCycles(input int n);
	repeat (n) @(posedge clk);
	#2;
endtask

// works from an idle bus and as a repeated start with scl low
task automatic busStart();
	waitCycles(SclHalf / 2);
	sda = 1'b1;
	waitCycles(SclHalf / 2);
	scl = 1'b1;
	waitCycles(SclHalf / 2);
	sda = 1'b0; // falling sda with scl high
	waitCycles(SclHalf / 2);
	scl = 1'b0;
endtask

task automatic busStop();
	waitCycles(SclHalf / 2);
	sda = 1'b0;
	waitCycles(SclHalf / 2);
	scl = 1'b1; // this rise is sampled like any other bit
	waitCycles(SclHalf / 2);
	sda = 1'b1;
	waitCycles(SclHalf / 2);
endtask

task automatic sendBit(input logic b);
	waitCycles(SclHalf / 2);
	sda = b; // sda only moves while scl is low
	waitCycles(SclHalf / 2);
	scl = 1'b1;
	waitCycles(SclHalf);
	scl = 1'b0;
endtask

task automatic sendByte(input logic [7:0] data, input logic ack);
	for (int i = 7; i >= 0; i--) begin
		sendBit(data[i]);
	end
	sendBit(ack);
endtask

// ********************
// compare tasks
// ********************

task automatic reportError(input string name, input string got, input string exp);
	$display("[ERROR] %0t %s got %s expected %s", $time, name, got, exp);
	$display("Test failed");
	$fatal(1);
endtask

task automatic checkStatus(input string name, input frameStatusE got, input frameStatusE exp);
	if (got !== exp) begin
		reportError(name, got.name(), exp.name());
	end
endtask

task automatic checkBits(input string name, input bitCountT got, input bitCountT exp);
	if (got !== exp) begin
		reportError(name, $sformatf("%0d", got), $sformatf("%0d", exp));
	end
endtask

task automatic checkCount(input string name, input frameCountT got, input frameCountT exp);
	if (got !== exp) begin
		reportError(name, $sformatf("%0d", got), $sformatf("%0d", exp));
	end
endtask

`endif

//--- dv/i2cFrameMonitorTb.sv
`timescale 1ns/1ps

module i2cFrameMonitorTb import i2cMonPkg::*; ();

	localparam int NumFrameBytes = 3;
	localparam int FrameBits = NumFrameBytes * BitsPerByte;
	localparam int DoneTimeout = 1000; // clk cycles, about two whole frames

	logic clk;
	logic reset;
	logic scl;
	logic sda;
	frameStatusE frameStatus;
	bitCountT bitsMatched;
	logic frameDone;
	frameStatusE lastResult;
	frameCountT matchCount;
	frameCountT failCount;

	logic [7:0] expBytes [NumFrameBytes] = '{8'hA0, 8'h5C, 8'h3E}; // first byte on the bus first
	logic txBits[$];
	frameStatusE expStatusQ[$];
	bitCountT expBitsQ[$];
	int seed = 32'hfec8_4e78;

	`include "i2cTbTasks.svh"

	i2cFrameMonitor UUT (
		.clk(clk),
		.reset(reset),
		.scl(scl),
		.sda(sda),
		.frameStatus(frameStatus),
		.bitsMatched(bitsMatched),
		.frameDone(frameDone),
		.lastResult(lastResult),
		.matchCount(matchCount),
		.failCount(failCount)
	);

	always #20 clk = ~clk;

	// ********************
	// reference model
	// ********************

	// walks the sampled levels in bus order and returns where the frame should end up
	function automatic frameStatusE refResult(input logic samples[$], input bit stopCut,
			output bitCountT expBits);
		int pos;
		logic want;
		expBits = '0;
		for (pos = 0; pos < samples.size(); pos++) begin
			if (pos % BitsPerByte == BitsPerByte - 1) begin
				want = 1'b0; // acknowledge slot
			end else begin
				want = expBytes[pos / BitsPerByte][7 - pos % BitsPerByte];
			end
			if (samples[pos] !== want) begin
				return statusFailed;
			end
			expBits = expBits + 1'b1;
			if (pos == FrameBits - 1) begin
				return statusMatched;
			end
		end
		if (stopCut) begin
			return statusFailed; // stop came before the last acknowledge
		end
		return statusActive;
	endfunction

	function automatic void loadGoodFrame();
		txBits.delete();
		for (int i = 0; i < NumFrameBytes; i++) begin
			for (int j = 7; j >= 0; j--) begin
				txBits.push_back(expBytes[i][j]);
			end
			txBits.push_back(1'b0);
		end
	endfunction

	task automatic waitDrained();
		int cycles;
		cycles = 0;
		while (expStatusQ.size() != 0) begin
			@(negedge clk);
			cycles++;
			if (cycles > DoneTimeout) begin
				$display("frameDone never came for a frame that should have ended");
				$display("Test failed");
				$fatal(1);
			end
		end
	endtask

	// the closing stop or repeated start raises scl once more, sampling sda 0 or 1
	task automatic driveFrame(input bit endStop);
		logic samples[$];
		bitCountT expBits;
		frameStatusE expStatus;
		samples = txBits;
		samples.push_back(endStop ? 1'b0 : 1'b1);
		expStatus = refResult(samples, endStop, expBits);
		if (expStatus != statusActive) begin
			expStatusQ.push_back(expStatus);
			expBitsQ.push_back(expBits);
		end
		busStart();
		foreach (txBits[i]) begin
			sendBit(txBits[i]);
		end
		if (endStop) begin
			busStop();
			waitDrained();
		end
	endtask

	// ********************
	// checking
	// ********************

	initial begin : resultCheck
		int idle;
		frameCountT expMatch;
		frameCountT expFail;
		frameStatusE wantStatus;
		idle = 0;
		expMatch = '0;
		expFail = '0;
		forever begin
			@(negedge clk);
			if (frameDone === 1'b1) begin
				if (expStatusQ.size() == 0) begin
					$display("frameDone pulsed while no frame was expected to end");
					$display("Test failed");
					$fatal(1);
				end
				wantStatus = expStatusQ[0];
				checkStatus("frameStatus", frameStatus, wantStatus);
				checkBits("bitsMatched", bitsMatched, expBitsQ[0]);
				if (wantStatus == statusMatched) begin
					expMatch = expMatch + 1'b1;
				end else begin
					expFail = expFail + 1'b1;
				end
				@(negedge clk); // result and counters follow one cycle later
				checkStatus("lastResult", lastResult, wantStatus);
				checkCount("matchCount", matchCount, expMatch);
				checkCount("failCount", failCount, expFail);
				void'(expStatusQ.pop_front());
				void'(expBitsQ.pop_front());
				idle = 0;
			end else if (expStatusQ.size() != 0) begin
				idle++;
				if (idle > DoneTimeout) begin
					$display("frameDone never came although a frame result was pending");
					$display("Test failed");
					$fatal(1);
				end
			end
		end
	end

	// ********************
	// stimulus
	// ********************

	initial begin
		int pos;
		int k;
		clk = 1'b0;
		reset = 1'b1;
		scl = 1'b1; // idle bus
		sda = 1'b1;
		repeat (2) @(posedge clk);
		#2;
		reset = 1'b0;
		@(negedge clk);
		checkStatus("frameStatus", frameStatus, statusIdle);
		checkStatus("lastResult", lastResult, statusIdle);
		checkBits("bitsMatched", bitsMatched, '0);
		checkCount("matchCount", matchCount, '0);
		checkCount("failCount", failCount, '0);

		loadGoodFrame();
		driveFrame(1'b1);

		repeat (3) begin
			loadGoodFrame();
			pos = ($unsigned($random(seed)) % NumFrameBytes) * BitsPerByte;
			pos = pos + $unsigned($random(seed)) % 8;
			txBits[pos] = ~txBits[pos]; // one data bit wrong
			driveFrame(1'b1);
		end

		repeat (3) begin
			loadGoodFrame();
			pos = ($unsigned($random(seed)) % NumFrameBytes) * BitsPerByte + BitsPerByte - 1;
			txBits[pos] = 1'b1; // missing acknowledge
			driveFrame(1'b1);
		end

		repeat (3) begin
			loadGoodFrame();
			// the stop's own scl rise sees an expected 0, so the frame is still active at the stop
			do begin
				k = $unsigned($random(seed)) % (FrameBits - 1);
			end while (txBits[k] !== 1'b0);
			while (txBits.size() > k) begin
				void'(txBits.pop_back());
			end
			driveFrame(1'b1);
		end

		repeat (2) begin
			loadGoodFrame();
			// the start's own scl rise sees an expected 1, so the frame is still active at the start
			do begin
				k = 1 + $unsigned($random(seed)) % (FrameBits - 2);
			end while (txBits[k] !== 1'b1);
			while (txBits.size() > k) begin
				void'(txBits.pop_back());
			end
			driveFrame(1'b0); // next start arrives mid frame
			loadGoodFrame();
			driveFrame(1'b1);
		end

		waitDrained();
		$display("Test passed");
		$finish;
	end

endmodule

//--- files.f
+incdir+include
design/i2cMonPkg.sv
design/i2cLineSync.sv
design/i2cFrameMatcher.sv
design/i2cStatusReport.sv
design/i2cFrameMonitor.sv
dv/i2cFrameMonitorTb.sv

//--- Bender.yml
package:
  name: i2c_frame_monitor

sources:
  - design/i2cMonPkg.sv
  - design/i2cLineSync.sv
  - design/i2cFrameMatcher.sv
  - design/i2cStatusReport.sv
  - design/i2cFrameMonitor.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/i2cFrameMonitorTb.sv
